// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f build.f --top-module tb_id_stage -o sim_tb
	./obj_dir/sim_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "FAILED"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "FAILED"; exit 1; fi
	@echo "PASSED"

clean:
	rm -rf obj_dir $(LOG)

// File: branch_unit.sv
`timescale 1ns/10ps

module branch_unit (
    input  logic                    accept,
    input  logic [id_pkg::xlen-1:0] pc,
    input  logic [id_pkg::xlen-1:0] rj_value,
    input  logic [id_pkg::xlen-1:0] rkd_value,
    dec_if.branch                   dec,
    output logic                    br_taken,
    output logic [id_pkg::xlen-1:0] br_target
);

    logic                    eq;
    logic                    lt;
    logic                    ltu;
    logic                    take;
    logic [id_pkg::xlen-1:0] target;

    assign eq  = rj_value == rkd_value;
    assign lt  = $signed(rj_value) < $signed(rkd_value);
    assign ltu = rj_value < rkd_value;

    assign take = dec.is_beq  &  eq  | dec.is_bne  & ~eq
                | dec.is_blt  &  lt  | dec.is_bge  & ~lt
                | dec.is_bltu &  ltu | dec.is_bgeu & ~ltu
                | dec.is_b | dec.is_bl | dec.is_jirl;

    // For jirl br_offs already holds the 16-bit offset.
    assign target = dec.is_jirl ? rj_value + dec.br_offs : pc + dec.br_offs;

    assign br_taken  = accept & take;
    assign br_target = accept ? target : '0;

endmodule

// File: build.f
id_pkg.sv
dec_if.sv
inst_decode.sv
operand_bypass.sv
branch_unit.sv
stage_reg.sv
id_stage.sv
id_stage_props.sv
tb_id_stage.sv

// File: dec_if.sv
`timescale 1ns/10ps

interface dec_if;

    logic [id_pkg::alu_op_w-1:0]   alu_op;
    logic                          src1_is_pc;
    logic                          src2_is_imm;
    logic                          gr_we;
    logic [id_pkg::reg_addr_w-1:0] dest;
    logic [id_pkg::xlen-1:0]       imm;
    logic                          src_reg_is_rd;
    logic [id_pkg::xlen-1:0]       br_offs;

    // Branch kind flags.
    logic is_jirl, is_b, is_bl;
    logic is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu;

    modport decode (
        output alu_op, src1_is_pc, src2_is_imm, gr_we, dest, imm, src_reg_is_rd, br_offs,
        output is_jirl, is_b, is_bl, is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu
    );
    modport branch (
        input is_jirl, is_b, is_bl, is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu,
        input br_offs
    );
    modport stage (input alu_op, src1_is_pc, src2_is_imm, gr_we, dest, imm);
    modport bypass (input src_reg_is_rd);

endinterface

// File: id_pkg.sv
package id_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 12;

    // One-hot ALU op bit positions.
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // Major opcodes in bits 31:26.
    localparam logic [5:0] op_alu  = 6'h00;
    localparam logic [5:0] op_jirl = 6'h13;
    localparam logic [5:0] op_b    = 6'h14;
    localparam logic [5:0] op_bl   = 6'h15;
    localparam logic [5:0] op_beq  = 6'h16;
    localparam logic [5:0] op_bne  = 6'h17;
    localparam logic [5:0] op_blt  = 6'h18;
    localparam logic [5:0] op_bge  = 6'h19;
    localparam logic [5:0] op_bltu = 6'h1a;
    localparam logic [5:0] op_bgeu = 6'h1b;
    localparam logic [6:0] op_lu12i_w   = 7'h0a;  // Bits 31:25.
    localparam logic [6:0] op_pcaddu12i = 7'h0e;  // Bits 31:25.

    // Bits 25:22 under op_alu.
    localparam logic [3:0] f22_reg3  = 4'h0;
    localparam logic [3:0] f22_shift = 4'h1;
    localparam logic [3:0] f22_slti  = 4'h8;
    localparam logic [3:0] f22_sltui = 4'h9;
    localparam logic [3:0] f22_addi  = 4'ha;
    localparam logic [3:0] f22_andi  = 4'hd;
    localparam logic [3:0] f22_ori   = 4'he;
    localparam logic [3:0] f22_xori  = 4'hf;

    // Bits 21:20.
    localparam logic [1:0] f20_reg3  = 2'h1;
    localparam logic [1:0] f20_shift = 2'h0;

    // Bits 19:15 of the three-register forms.
    localparam logic [4:0] f15_add  = 5'h00;
    localparam logic [4:0] f15_sub  = 5'h02;
    localparam logic [4:0] f15_slt  = 5'h04;
    localparam logic [4:0] f15_sltu = 5'h05;
    localparam logic [4:0] f15_nor  = 5'h08;
    localparam logic [4:0] f15_and  = 5'h09;
    localparam logic [4:0] f15_or   = 5'h0a;
    localparam logic [4:0] f15_xor  = 5'h0b;
    localparam logic [4:0] f15_sll  = 5'h0e;
    localparam logic [4:0] f15_srl  = 5'h0f;
    localparam logic [4:0] f15_sra  = 5'h10;
    // Shift by immediate.
    localparam logic [4:0] f15_slli = 5'h01;
    localparam logic [4:0] f15_srli = 5'h09;
    localparam logic [4:0] f15_srai = 5'h11;

    localparam logic [reg_addr_w-1:0] link_reg = 5'd1;
    localparam logic [xlen-1:0]       reset_pc = 32'h1c00_0000;

    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [3:0] f22;
            logic [1:0] f20;
            logic [4:0] f15;
            logic [4:0] rk;
            logic [4:0] rj;
            logic [4:0] rd;
        } r;
        struct packed {
            logic [9:0]  op_hi;
            logic [11:0] i12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } i;
    } inst_word_u;

endpackage

// File: id_stage.sv
`timescale 1ns/10ps

module id_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    output logic                          in_ready,
    output logic                          out_valid,
    input  logic                          out_ready,
    input  logic [id_pkg::xlen-1:0]       inst,
    input  logic [id_pkg::xlen-1:0]       pc,
    output logic [id_pkg::reg_addr_w-1:0] rf_raddr1,
    output logic [id_pkg::reg_addr_w-1:0] rf_raddr2,
    input  logic [id_pkg::xlen-1:0]       rf_rdata1,
    input  logic [id_pkg::xlen-1:0]       rf_rdata2,
    input  logic [id_pkg::xlen-1:0]       ex_result,
    input  logic                          wb_valid,
    input  logic                          wb_we,
    input  logic [id_pkg::reg_addr_w-1:0] wb_dest,
    input  logic [id_pkg::xlen-1:0]       wb_data,
    output logic                          br_taken,
    output logic [id_pkg::xlen-1:0]       br_target,
    output logic [id_pkg::alu_op_w-1:0]   alu_op,
    output logic                          src1_is_pc,
    output logic                          src2_is_imm,
    output logic                          gr_we,
    output logic [id_pkg::reg_addr_w-1:0] dest,
    output logic [id_pkg::xlen-1:0]       imm,
    output logic [id_pkg::xlen-1:0]       pc_out,
    output logic [id_pkg::xlen-1:0]       rj_value,
    output logic [id_pkg::xlen-1:0]       rkd_value
);

    logic                    accept;
    logic [id_pkg::xlen-1:0] rj_fwd;
    logic [id_pkg::xlen-1:0] rkd_fwd;

    dec_if dec ();

    inst_decode u_decode (.inst(inst), .dec(dec));

    // The held bundle is the execute-stage forwarding source.
    operand_bypass u_bypass (
        .rj(inst[9:5]), .rd(inst[4:0]), .rk(inst[14:10]),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .ex_result(ex_result), .wb_data(wb_data),
        .ex_valid(out_valid), .ex_we(gr_we), .ex_dest(dest),
        .wb_valid(wb_valid), .wb_we(wb_we), .wb_dest(wb_dest),
        .dec(dec),
        .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
        .rj_value(rj_fwd), .rkd_value(rkd_fwd)
    );

    branch_unit u_branch (
        .accept(accept), .pc(pc), .rj_value(rj_fwd), .rkd_value(rkd_fwd),
        .dec(dec), .br_taken(br_taken), .br_target(br_target)
    );

    stage_reg u_stage (
        .clk(clk), .rst(rst), .in_valid(in_valid), .out_ready(out_ready),
        .pc(pc), .rj_value(rj_fwd), .rkd_value(rkd_fwd), .dec(dec),
        .in_ready(in_ready), .accept(accept), .out_valid(out_valid),
        .alu_op(alu_op), .src1_is_pc(src1_is_pc), .src2_is_imm(src2_is_imm),
        .gr_we(gr_we), .dest(dest), .imm(imm), .pc_out(pc_out),
        .rj_value_out(rj_value), .rkd_value_out(rkd_value)
    );

endmodule

// File: id_stage_props.sv
`timescale 1ns/10ps

module id_stage_props (
    input logic                          clk,
    input logic                          rst,
    input logic                          in_valid,
    input logic                          out_ready,
    input logic                          out_valid,
    input logic                          br_taken,
    input logic                          gr_we,
    input logic [id_pkg::alu_op_w-1:0]   alu_op,
    input logic                          src1_is_pc,
    input logic                          src2_is_imm,
    input logic [id_pkg::reg_addr_w-1:0] dest,
    input logic [id_pkg::xlen-1:0]       imm,
    input logic [id_pkg::xlen-1:0]       pc_out,
    input logic [id_pkg::xlen-1:0]       rj_value,
    input logic [id_pkg::xlen-1:0]       rkd_value
);

    a_reset_clears: assert property (@(posedge clk) rst |=> !out_valid && !gr_we && alu_op == '0)
        else $error("out_valid, gr_we or alu_op not cleared by reset");

    a_taken_on_accept: assert property (@(posedge clk) br_taken |-> in_valid && out_ready)
        else $error("br_taken high outside an accept cycle");

    // Bundle and out_valid freeze under back-pressure.
    a_hold: assert property (@(posedge clk) disable iff (rst)
        !out_ready |=> $stable({out_valid, alu_op, src1_is_pc, src2_is_imm, gr_we, dest,
                                imm, pc_out, rj_value, rkd_value}))
        else $error("registered outputs changed while out_ready was low");

endmodule

bind id_stage id_stage_props u_props (.*);

// File: inst_decode.sv
`timescale 1ns/10ps

module inst_decode (
    input  id_pkg::inst_word_u inst,
    dec_if.decode              dec
);

    logic is_reg3;
    logic is_shift;
    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor, inst_and;
    logic inst_or, inst_xor, inst_sll_w, inst_srl_w, inst_sra_w;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic inst_lu12i_w, inst_pcaddu12i;
    logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic inst_blt, inst_bge, inst_bltu, inst_bgeu;
    logic need_si20, need_ui12, need_si26, src2_is_4;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;
    logic [id_pkg::alu_op_w-1:0] alu_op;

    // #########################################################################
    // Recognition
    // #########################################################################
    assign is_reg3  = inst.r.op == id_pkg::op_alu && inst.r.f22 == id_pkg::f22_reg3
                      && inst.r.f20 == id_pkg::f20_reg3;
    assign is_shift = inst.r.op == id_pkg::op_alu && inst.r.f22 == id_pkg::f22_shift
                      && inst.r.f20 == id_pkg::f20_shift;

    assign inst_add_w  = is_reg3 && inst.r.f15 == id_pkg::f15_add;
    assign inst_sub_w  = is_reg3 && inst.r.f15 == id_pkg::f15_sub;
    assign inst_slt    = is_reg3 && inst.r.f15 == id_pkg::f15_slt;
    assign inst_sltu   = is_reg3 && inst.r.f15 == id_pkg::f15_sltu;
    assign inst_nor    = is_reg3 && inst.r.f15 == id_pkg::f15_nor;
    assign inst_and    = is_reg3 && inst.r.f15 == id_pkg::f15_and;
    assign inst_or     = is_reg3 && inst.r.f15 == id_pkg::f15_or;
    assign inst_xor    = is_reg3 && inst.r.f15 == id_pkg::f15_xor;
    assign inst_sll_w  = is_reg3 && inst.r.f15 == id_pkg::f15_sll;
    assign inst_srl_w  = is_reg3 && inst.r.f15 == id_pkg::f15_srl;
    assign inst_sra_w  = is_reg3 && inst.r.f15 == id_pkg::f15_sra;
    assign inst_slli_w = is_shift && inst.r.f15 == id_pkg::f15_slli;
    assign inst_srli_w = is_shift && inst.r.f15 == id_pkg::f15_srli;
    assign inst_srai_w = is_shift && inst.r.f15 == id_pkg::f15_srai;

    // 12-bit immediate forms match on bits 31:22.
    assign inst_slti   = inst.i.op_hi == {id_pkg::op_alu, id_pkg::f22_slti};
    assign inst_sltui  = inst.i.op_hi == {id_pkg::op_alu, id_pkg::f22_sltui};
    assign inst_addi_w = inst.i.op_hi == {id_pkg::op_alu, id_pkg::f22_addi};
    assign inst_andi   = inst.i.op_hi == {id_pkg::op_alu, id_pkg::f22_andi};
    assign inst_ori    = inst.i.op_hi == {id_pkg::op_alu, id_pkg::f22_ori};
    assign inst_xori   = inst.i.op_hi == {id_pkg::op_alu, id_pkg::f22_xori};

    assign inst_lu12i_w   = {inst.r.op, inst.r.f22[3]} == id_pkg::op_lu12i_w;
    assign inst_pcaddu12i = {inst.r.op, inst.r.f22[3]} == id_pkg::op_pcaddu12i;

    assign inst_jirl = inst.r.op == id_pkg::op_jirl;
    assign inst_b    = inst.r.op == id_pkg::op_b;
    assign inst_bl   = inst.r.op == id_pkg::op_bl;
    assign inst_beq  = inst.r.op == id_pkg::op_beq;
    assign inst_bne  = inst.r.op == id_pkg::op_bne;
    assign inst_blt  = inst.r.op == id_pkg::op_blt;
    assign inst_bge  = inst.r.op == id_pkg::op_bge;
    assign inst_bltu = inst.r.op == id_pkg::op_bltu;
    assign inst_bgeu = inst.r.op == id_pkg::op_bgeu;

    // #########################################################################
    // Control
    // #########################################################################
    always_comb begin
        alu_op[id_pkg::alu_add]  = inst_add_w | inst_addi_w | inst_jirl | inst_bl
                                   | inst_pcaddu12i;  // Link and PC-relative adds too.
        alu_op[id_pkg::alu_sub]  = inst_sub_w;
        alu_op[id_pkg::alu_slt]  = inst_slt | inst_slti;
        alu_op[id_pkg::alu_sltu] = inst_sltu | inst_sltui;
        alu_op[id_pkg::alu_and]  = inst_and | inst_andi;
        alu_op[id_pkg::alu_nor]  = inst_nor;
        alu_op[id_pkg::alu_or]   = inst_or | inst_ori;
        alu_op[id_pkg::alu_xor]  = inst_xor | inst_xori;
        alu_op[id_pkg::alu_sll]  = inst_sll_w | inst_slli_w;
        alu_op[id_pkg::alu_srl]  = inst_srl_w | inst_srli_w;
        alu_op[id_pkg::alu_sra]  = inst_sra_w | inst_srai_w;
        alu_op[id_pkg::alu_lui]  = inst_lu12i_w;
    end

    assign dec.alu_op      = alu_op;
    assign dec.gr_we       = |alu_op;  // Every register writer carries an ALU op.
    assign dec.src1_is_pc  = inst_jirl | inst_bl | inst_pcaddu12i;
    assign dec.src2_is_imm = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w
                             | inst_slti | inst_sltui | inst_andi | inst_ori | inst_xori
                             | inst_lu12i_w | inst_pcaddu12i | inst_jirl | inst_bl;
    assign dec.dest        = inst_bl ? id_pkg::link_reg : inst.r.rd;
    assign dec.src_reg_is_rd = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

    assign dec.is_jirl = inst_jirl;
    assign dec.is_b    = inst_b;
    assign dec.is_bl   = inst_bl;
    assign dec.is_beq  = inst_beq;
    assign dec.is_bne  = inst_bne;
    assign dec.is_blt  = inst_blt;
    assign dec.is_bge  = inst_bge;
    assign dec.is_bltu = inst_bltu;
    assign dec.is_bgeu = inst_bgeu;

    // #########################################################################
    // Immediates and branch offset
    // #########################################################################
    assign i12 = inst.i.i12;
    assign i16 = {inst.r.f22, inst.i.i12};                    // Bits 25:10.
    assign i20 = {inst.r.f22[2:0], inst.i.i12, inst.i.rj};    // Bits 24:5.
    assign i26 = {inst.r.rj, inst.r.rd, inst.r.f22, inst.i.i12};

    assign need_si20 = inst_lu12i_w | inst_pcaddu12i;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign need_si26 = inst_b | inst_bl;
    assign src2_is_4 = inst_jirl | inst_bl;

    assign dec.imm = src2_is_4 ? 32'd4               :
                     need_si20 ? {i20, 12'b0}        :
                     need_ui12 ? {20'b0, i12}        :
                                 {{20{i12[11]}}, i12};

    assign dec.br_offs = need_si26 ? {{4{i26[25]}}, i26, 2'b00}
                                   : {{14{i16[15]}}, i16, 2'b00};

endmodule

// File: operand_bypass.sv
`timescale 1ns/10ps

module operand_bypass (
    input  logic [id_pkg::reg_addr_w-1:0] rj,
    input  logic [id_pkg::reg_addr_w-1:0] rd,
    input  logic [id_pkg::reg_addr_w-1:0] rk,
    input  logic [id_pkg::xlen-1:0]       rf_rdata1,
    input  logic [id_pkg::xlen-1:0]       rf_rdata2,
    input  logic [id_pkg::xlen-1:0]       ex_result,
    input  logic [id_pkg::xlen-1:0]       wb_data,
    input  logic                          ex_valid,
    input  logic                          ex_we,
    input  logic [id_pkg::reg_addr_w-1:0] ex_dest,
    input  logic                          wb_valid,
    input  logic                          wb_we,
    input  logic [id_pkg::reg_addr_w-1:0] wb_dest,
    dec_if.bypass                         dec,
    output logic [id_pkg::reg_addr_w-1:0] rf_raddr1,
    output logic [id_pkg::reg_addr_w-1:0] rf_raddr2,
    output logic [id_pkg::xlen-1:0]       rj_value,
    output logic [id_pkg::xlen-1:0]       rkd_value
);

    logic ex_hit1, ex_hit2;
    logic wb_hit1, wb_hit2;

    // Register 0 is hardwired and never forwarded.
    function automatic logic fwd_hit(
        input logic                          valid,
        input logic                          we,
        input logic [id_pkg::reg_addr_w-1:0] dest,
        input logic [id_pkg::reg_addr_w-1:0] addr
    );
        return valid && we && dest == addr && addr != '0;
    endfunction

    assign rf_raddr1 = rj;
    assign rf_raddr2 = dec.src_reg_is_rd ? rd : rk;  // Branches compare rj with rd.

    assign ex_hit1 = fwd_hit(ex_valid, ex_we, ex_dest, rf_raddr1);
    assign ex_hit2 = fwd_hit(ex_valid, ex_we, ex_dest, rf_raddr2);
    assign wb_hit1 = fwd_hit(wb_valid, wb_we, wb_dest, rf_raddr1);
    assign wb_hit2 = fwd_hit(wb_valid, wb_we, wb_dest, rf_raddr2);

    // Youngest producer wins.
    assign rj_value  = ex_hit1 ? ex_result :
                       wb_hit1 ? wb_data   :
                                 rf_rdata1;
    assign rkd_value = ex_hit2 ? ex_result :
                       wb_hit2 ? wb_data   :
                                 rf_rdata2;

endmodule

// File: stage_reg.sv
`timescale 1ns/10ps

module stage_reg (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  logic                          out_ready,
    input  logic [id_pkg::xlen-1:0]       pc,
    input  logic [id_pkg::xlen-1:0]       rj_value,
    input  logic [id_pkg::xlen-1:0]       rkd_value,
    dec_if.stage                          dec,
    output logic                          in_ready,
    output logic                          accept,
    output logic                          out_valid,
    output logic [id_pkg::alu_op_w-1:0]   alu_op,
    output logic                          src1_is_pc,
    output logic                          src2_is_imm,
    output logic                          gr_we,
    output logic [id_pkg::reg_addr_w-1:0] dest,
    output logic [id_pkg::xlen-1:0]       imm,
    output logic [id_pkg::xlen-1:0]       pc_out,
    output logic [id_pkg::xlen-1:0]       rj_value_out,
    output logic [id_pkg::xlen-1:0]       rkd_value_out
);

    // Never stalls itself, so only downstream back-pressure matters.
    assign in_ready = ~rst & (out_ready | ~in_valid);
    assign accept   = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (out_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_op        <= '0;
            src1_is_pc    <= 1'b0;
            src2_is_imm   <= 1'b0;
            gr_we         <= 1'b0;
            dest          <= '0;
            imm           <= '0;
            pc_out        <= id_pkg::reset_pc;
            rj_value_out  <= '0;
            rkd_value_out <= '0;
        end else if (accept) begin
            alu_op        <= dec.alu_op;
            src1_is_pc    <= dec.src1_is_pc;
            src2_is_imm   <= dec.src2_is_imm;
            gr_we         <= dec.gr_we;
            dest          <= dec.dest;
            imm           <= dec.imm;
            pc_out        <= pc;
            rj_value_out  <= rj_value;
            rkd_value_out <= rkd_value;
        end
    end

endmodule

// File: tb_id_stage.sv
`timescale 1ns/10ps

module tb_id_stage;

    typedef struct packed {
        logic [id_pkg::alu_op_w-1:0]   alu_op;
        logic                          src1_is_pc;
        logic                          src2_is_imm;
        logic                          gr_we;
        logic [id_pkg::reg_addr_w-1:0] dest;
        logic [id_pkg::xlen-1:0]       imm;
        logic [id_pkg::xlen-1:0]       pc;
        logic [id_pkg::xlen-1:0]       rj_value;
        logic [id_pkg::xlen-1:0]       rkd_value;
        logic [id_pkg::reg_addr_w-1:0] raddr1;
        logic [id_pkg::reg_addr_w-1:0] raddr2;
        logic                          br_taken;
        logic [id_pkg::xlen-1:0]       br_target;
    } expect_t;

    // Kinds 0-13 reg/shift, 14-19 imm12, 20-21 imm20, 22-30 jirl b bl beq..bgeu.
    localparam logic [31:0] base_word [31] = '{
        32'h0010_0000, 32'h0011_0000, 32'h0012_0000, 32'h0012_8000, 32'h0014_0000,
        32'h0014_8000, 32'h0015_0000, 32'h0015_8000, 32'h0017_0000, 32'h0017_8000,
        32'h0018_0000, 32'h0040_8000, 32'h0044_8000, 32'h0048_8000,
        32'h0200_0000, 32'h0240_0000, 32'h0280_0000, 32'h0340_0000, 32'h0380_0000,
        32'h03c0_0000, 32'h1400_0000, 32'h1c00_0000,
        32'h4c00_0000, 32'h5000_0000, 32'h5400_0000, 32'h5800_0000, 32'h5c00_0000,
        32'h6000_0000, 32'h6400_0000, 32'h6800_0000, 32'h6c00_0000
    };

    logic clk = 1'b0;
    logic rst, in_valid, in_ready, out_valid, out_ready, wb_valid, wb_we;
    logic br_taken, src1_is_pc, src2_is_imm, gr_we;
    logic [id_pkg::xlen-1:0] inst, pc, rf_rdata1, rf_rdata2, ex_result, wb_data;
    logic [id_pkg::xlen-1:0] br_target, imm, pc_out, rj_value, rkd_value;
    logic [id_pkg::reg_addr_w-1:0] rf_raddr1, rf_raddr2, wb_dest, dest;
    logic [id_pkg::alu_op_w-1:0] alu_op;
    logic [id_pkg::xlen-1:0] regs [32];
    logic [31:0] seed = 32'hcf82_53bd;
    logic armed = 1'b0;
    logic held_v = 1'b0;
    expect_t held;
    expect_t cur;
    logic acc;
    int err_count = 0;
    int test_base = 0;
    int passed = 0;
    int failed = 0;

    always #50 clk = ~clk;

    id_stage u_dut (.*);

    assign rf_rdata1 = regs[rf_raddr1];  // Combinational register file.
    assign rf_rdata2 = regs[rf_raddr2];

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand32();
        seed = lcg_next(seed);
        return seed;
    endfunction

    function automatic int pick(input int n);
        return int'(rand32() >> 1) % n;
    endfunction

    function automatic logic [31:0] make_inst(input int k, input logic [31:0] r);
        int nbits;
        nbits = k < 14 ? 17 : k < 20 ? 10 : k < 22 ? 7 : 6;
        return base_word[k] | (r >> nbits);
    endfunction

    function automatic logic [31:0] pick_operand(input logic [4:0] addr, input logic hv,
                                                 input logic hwe, input logic [4:0] hdest);
        if (hv && hwe && hdest == addr && addr != 5'd0) return ex_result;
        if (wb_valid && wb_we && wb_dest == addr && addr != 5'd0) return wb_data;
        return regs[addr];
    endfunction

    function automatic expect_t ref_decode(input logic [31:0] w, input logic [31:0] addr,
                                           input logic hv, input logic hwe,
                                           input logic [4:0] hdest);
        expect_t e;
        logic [16:0] f17;
        logic [9:0] f10;
        logic [5:0] f6;
        logic cond, reg3, shift, imm12, u20;
        logic [31:0] offs;
        f17 = w[31:15];
        f10 = w[31:22];
        f6 = w[31:26];
        e = '0;
        cond = f6 >= 6'h16 && f6 <= 6'h1b;
        reg3 = f17 inside {17'h00020, 17'h00022, 17'h00024, 17'h00025, 17'h00028, 17'h00029,
                           17'h0002a, 17'h0002b, 17'h0002e, 17'h0002f, 17'h00030};
        shift = f17 inside {17'h00081, 17'h00089, 17'h00091};
        imm12 = f10 inside {10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e, 10'h00f};
        u20 = w[31:25] inside {7'h0a, 7'h0e};
        case (f17)
            17'h00020: e.alu_op[id_pkg::alu_add] = 1'b1;
            17'h00022: e.alu_op[id_pkg::alu_sub] = 1'b1;
            17'h00024: e.alu_op[id_pkg::alu_slt] = 1'b1;
            17'h00025: e.alu_op[id_pkg::alu_sltu] = 1'b1;
            17'h00028: e.alu_op[id_pkg::alu_nor] = 1'b1;
            17'h00029: e.alu_op[id_pkg::alu_and] = 1'b1;
            17'h0002a: e.alu_op[id_pkg::alu_or] = 1'b1;
            17'h0002b: e.alu_op[id_pkg::alu_xor] = 1'b1;
            17'h0002e, 17'h00081: e.alu_op[id_pkg::alu_sll] = 1'b1;
            17'h0002f, 17'h00089: e.alu_op[id_pkg::alu_srl] = 1'b1;
            17'h00030, 17'h00091: e.alu_op[id_pkg::alu_sra] = 1'b1;
            default: ;
        endcase
        case (f10)
            10'h008: e.alu_op[id_pkg::alu_slt] = 1'b1;
            10'h009: e.alu_op[id_pkg::alu_sltu] = 1'b1;
            10'h00a: e.alu_op[id_pkg::alu_add] = 1'b1;
            10'h00d: e.alu_op[id_pkg::alu_and] = 1'b1;
            10'h00e: e.alu_op[id_pkg::alu_or] = 1'b1;
            10'h00f: e.alu_op[id_pkg::alu_xor] = 1'b1;
            default: ;
        endcase
        if (w[31:25] == 7'h0a) e.alu_op[id_pkg::alu_lui] = 1'b1;
        if (w[31:25] == 7'h0e || f6 == 6'h13 || f6 == 6'h15) e.alu_op[id_pkg::alu_add] = 1'b1;
        e.gr_we = reg3 || shift || imm12 || u20 || f6 == 6'h13 || f6 == 6'h15;
        e.src1_is_pc = f6 == 6'h13 || f6 == 6'h15 || w[31:25] == 7'h0e;
        e.src2_is_imm = shift || imm12 || u20 || f6 == 6'h13 || f6 == 6'h15;
        e.dest = f6 == 6'h15 ? 5'd1 : w[4:0];
        if (f6 == 6'h13 || f6 == 6'h15) e.imm = 32'd4;
        else if (u20) e.imm = {w[24:5], 12'b0};
        else if (f10 inside {10'h00d, 10'h00e, 10'h00f}) e.imm = {20'b0, w[21:10]};
        else e.imm = {{20{w[21]}}, w[21:10]};
        e.pc = addr;
        e.raddr1 = w[9:5];
        e.raddr2 = cond ? w[4:0] : w[14:10];
        e.rj_value = pick_operand(e.raddr1, hv, hwe, hdest);
        e.rkd_value = pick_operand(e.raddr2, hv, hwe, hdest);
        if (f6 == 6'h14 || f6 == 6'h15) offs = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
        else offs = {{14{w[25]}}, w[25:10], 2'b00};
        e.br_target = f6 == 6'h13 ? e.rj_value + offs : addr + offs;
        case (f6)
            6'h13, 6'h14, 6'h15: e.br_taken = 1'b1;
            6'h16: e.br_taken = e.rj_value == e.rkd_value;
            6'h17: e.br_taken = e.rj_value != e.rkd_value;
            6'h18: e.br_taken = $signed(e.rj_value) < $signed(e.rkd_value);
            6'h19: e.br_taken = $signed(e.rj_value) >= $signed(e.rkd_value);
            6'h1a: e.br_taken = e.rj_value < e.rkd_value;
            6'h1b: e.br_taken = e.rj_value >= e.rkd_value;
            default: e.br_taken = 1'b0;
        endcase
        return e;
    endfunction

    task automatic check_word(input string name, input logic [id_pkg::xlen-1:0] exp, act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_op(input string name, input logic [id_pkg::alu_op_w-1:0] exp, act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_reg(input string name, input logic [id_pkg::reg_addr_w-1:0] exp, act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
            err_count++;
        end
    endtask

    // ########################################################################
    // Checker samples mid-cycle when every input and output has settled.
    // ########################################################################
    always @(negedge clk) begin
        if (armed) begin
            check_bit("out_valid", held_v, out_valid);
            check_op("alu_op", held.alu_op, alu_op);
            check_bit("src1_is_pc", held.src1_is_pc, src1_is_pc);
            check_bit("src2_is_imm", held.src2_is_imm, src2_is_imm);
            check_bit("gr_we", held.gr_we, gr_we);
            check_reg("dest", held.dest, dest);
            check_word("imm", held.imm, imm);
            check_word("pc_out", held.pc, pc_out);
            check_word("rj_value", held.rj_value, rj_value);
            check_word("rkd_value", held.rkd_value, rkd_value);
            cur = ref_decode(inst, pc, held_v, held.gr_we, held.dest);
            acc = !rst && in_valid && out_ready;
            check_bit("in_ready", !rst && (out_ready || !in_valid), in_ready);
            check_bit("br_taken", acc && cur.br_taken, br_taken);
            check_word("br_target", acc ? cur.br_target : 32'd0, br_target);
            if (acc) begin
                check_reg("rf_raddr1", cur.raddr1, rf_raddr1);
                check_reg("rf_raddr2", cur.raddr2, rf_raddr2);
            end
            // Next state of the stage register.
            if (rst) begin
                held = '0;
                held.pc = id_pkg::reset_pc;
                held_v = 1'b0;
            end else begin
                if (out_ready) held_v = in_valid;
                if (acc) held = cur;
            end
        end
    end

    task automatic issue(input int kmin, input int kmax, input bit narrow, input bit fwd,
                         input bit gap, input int pct);
        logic [31:0] w;
        int waited;
        w = make_inst(kmin + pick(kmax - kmin + 1), rand32());
        if (narrow) w = w & 32'hffff_8c63;  // Registers 0 to 3 only.
        if (gap) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
        @(posedge clk);
        in_valid <= 1'b1;
        inst <= w;
        pc <= rand32() & 32'hffff_fffc;
        ex_result <= rand32();
        wb_valid <= fwd && pick(2) == 1;
        wb_we <= pick(4) != 0;
        wb_dest <= narrow ? 5'(pick(4)) : 5'(pick(32));
        wb_data <= rand32();
        out_ready <= pick(100) < pct;
        waited = 0;
        @(negedge clk);
        while (!in_ready) begin
            if (waited == 20) begin
                $display("Timeout: instruction %h not accepted within 20 cycles", w);
                $display("Test failed");
                $finish;
            end
            waited++;
            @(posedge clk);
            out_ready <= waited > 2 || pick(100) < pct;
            @(negedge clk);
        end
    endtask

    task automatic run_test(input string name, input int kmin, input int kmax,
                            input bit narrow, input bit fwd, input bit gap,
                            input int pct, input int n);
        test_base = err_count;
        regs[0] = '0;
        for (int i = 1; i < 32; i++) regs[i] = rand32();
        for (int i = 0; i < n; i++) issue(kmin, kmax, narrow, fwd, gap, pct);
        @(posedge clk);
        in_valid <= 1'b0;
        out_ready <= 1'b1;
        @(negedge clk);  // Last bundle is checked here.
        @(posedge clk);
        finish_test(name);
    endtask

    task automatic finish_test(input string name);
        if (err_count == test_base) passed++;
        else failed++;
        $display("%s: %0d errors", name, err_count - test_base);
        test_base = err_count;
    endtask

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        out_ready = 1'b0;
        inst = '0;
        pc = '0;
        ex_result = '0;
        wb_valid = 1'b0;
        wb_we = 1'b0;
        wb_dest = '0;
        wb_data = '0;
        held = '0;
        held.pc = id_pkg::reset_pc;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        @(posedge clk);
        armed = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        out_ready <= 1'b1;
        @(negedge clk);
        @(posedge clk);
        finish_test("reset values");
        run_test("alu and immediate decode", 0, 21, 0, 0, 0, 100, 150);
        run_test("read addresses and operands", 0, 30, 0, 0, 1, 100, 100);
        run_test("forwarding priority", 0, 30, 1, 1, 0, 100, 200);
        run_test("branch resolution", 22, 30, 1, 1, 0, 100, 200);
        run_test("back-pressure", 0, 30, 1, 1, 0, 50, 200);
        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 passed, failed, err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
